// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Datapath and register index widths
  localparam int data_w = 16;
  localparam int reg_addr_w = 4;

  // Kept opcodes only, 0011 and 0111 are unused
  typedef enum logic [3:0] {
    op_add = 4'b0000,
    op_sub = 4'b0001,
    op_xor = 4'b0010,
    op_sll = 4'b0100,
    op_sra = 4'b0101,
    op_ror = 4'b0110,
    op_lw  = 4'b1000,
    op_sw  = 4'b1001,
    op_llb = 4'b1010,
    op_lhb = 4'b1011,
    op_b   = 4'b1100,
    op_br  = 4'b1101,
    op_pcs = 4'b1110,
    op_hlt = 4'b1111
  } opcode_t;

  // Branch condition field, bits 11:9
  typedef enum logic [2:0] {
    cond_ne, cond_eq, cond_gt, cond_lt, cond_ge, cond_le, cond_ov, cond_al
  } cond_t;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  typedef struct packed {
    logic [data_w-1:0] inst;
    logic [data_w-1:0] pc_plus2;
  } if_id_t;

  typedef struct packed {
    opcode_t               op;
    logic [data_w-1:0]     rs_val;
    logic [data_w-1:0]     rt_val;
    logic [data_w-1:0]     imm;
    logic [3:0]            shamt;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [data_w-1:0]     pc_plus2;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  halt;
  } id_ex_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    logic [reg_addr_w-1:0] rd;
    logic [data_w-1:0]     alu;
    logic [data_w-1:0]     load_data;
    logic                  halt;
  } mem_wb_t;

  typedef enum logic [1:0] {fwd_none, fwd_ex_mem, fwd_mem_wb} fwd_sel_t;

  // LLB r0 with zero byte, touches no flags and no visible register
  localparam logic [data_w-1:0] nop_inst = 16'hA000;
  localparam opcode_t hlt_op = op_hlt;

endpackage

`default_nettype wire

// File: ex_mem_if.sv
`default_nettype none

interface ex_mem_if;
  import cpu_pkg::*;

  logic                  valid;
  logic                  reg_write;
  logic                  mem_read;
  logic                  mem_write;
  logic [reg_addr_w-1:0] rd;
  logic [data_w-1:0]     alu_out;
  logic [data_w-1:0]     store_data;
  logic                  halt;

  // Execute owns the register, alu_out read back for forwarding
  modport ex (output valid, reg_write, mem_read, mem_write, rd, alu_out, store_data, halt);
  modport mem (input valid, reg_write, mem_read, mem_write, rd, alu_out, store_data, halt);
  modport hzd (input reg_write, mem_read, rd);

endinterface

`default_nettype wire

// File: pipe_reg.sv
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     hold,
  input  logic     clear,
  input  payload_t bubble,
  input  payload_t d,
  output payload_t q
);

  // Clear wins over hold
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= bubble;
    end else if (clear) begin
      q <= bubble;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: fetch_stage.sv
`default_nettype none

module fetch_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [cpu_pkg::data_w-1:0] inst,
  input  logic                       stall,
  input  logic                       br_taken,
  input  logic [cpu_pkg::data_w-1:0] br_target,
  output logic [cpu_pkg::data_w-1:0] pc,
  output cpu_pkg::if_id_t            if_id
);
  import cpu_pkg::*;

  logic [data_w-1:0] pc_plus2;
  logic              fetch_hlt;
  logic [data_w-1:0] pc_next;

  assign pc_plus2 = pc + 16'd2;
  assign fetch_hlt = (inst[15:12] == hlt_op);

  // Stall first, then redirect, HLT freezes only on the fall-through path
  always_comb begin
    if (stall) begin
      pc_next = pc;
    end else if (br_taken) begin
      pc_next = br_target;
    end else if (fetch_hlt) begin
      pc_next = pc;
    end else begin
      pc_next = pc_plus2;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  assign if_id.inst = inst;
  assign if_id.pc_plus2 = pc_plus2;

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

module decode_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  cpu_pkg::if_id_t                if_id,
  input  logic                           wb_en,
  input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [cpu_pkg::data_w-1:0]     wb_data,
  input  cpu_pkg::flags_t                flags,
  output cpu_pkg::id_ex_t                id_ex,
  output logic [cpu_pkg::reg_addr_w-1:0] rs,
  output logic [cpu_pkg::reg_addr_w-1:0] rt,
  output logic                           uses_rt,
  output logic                           is_branch,
  output logic                           is_br_reg,
  output logic                           br_taken,
  output logic [cpu_pkg::data_w-1:0]     br_target
);
  import cpu_pkg::*;

  logic [data_w-1:0]     regs [16];
  opcode_t               op;
  cond_t                 cond;
  logic [reg_addr_w-1:0] rd;
  logic                  uses_rs;
  logic                  src2_hi;
  logic [data_w-1:0]     rs_val;
  logic [data_w-1:0]     rt_val;
  logic                  cond_met;

  assign op = opcode_t'(if_id.inst[15:12]);
  assign cond = cond_t'(if_id.inst[11:9]);
  assign rd = if_id.inst[11:8];

  // SW data and LLB/LHB old value come from bits 11:8
  assign src2_hi = (op == op_sw) || (op == op_llb) || (op == op_lhb);
  assign uses_rt = (op == op_add) || (op == op_sub) || (op == op_xor) || src2_hi;
  assign uses_rs = !op[3] || (op == op_lw) || (op == op_sw) || (op == op_br);
  // Unused rs reads as r0 so it never matches a hazard
  assign rs = uses_rs ? if_id.inst[7:4] : '0;
  assign rt = src2_hi ? if_id.inst[11:8] : if_id.inst[3:0];

  // Register file, r0 is never written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Writeback bypassed into same-cycle read
  assign rs_val = (rs == '0) ? '0 : (wb_en && wb_rd == rs) ? wb_data : regs[rs];
  assign rt_val = (rt == '0) ? '0 : (wb_en && wb_rd == rt) ? wb_data : regs[rt];

  always_comb begin
    case (cond)
      cond_ne: cond_met = !flags.z;
      cond_eq: cond_met = flags.z;
      cond_gt: cond_met = !flags.z && !flags.n;
      cond_lt: cond_met = flags.n;
      cond_ge: cond_met = flags.z || !flags.n;
      cond_le: cond_met = flags.n || flags.z;
      cond_ov: cond_met = flags.v;
      default: cond_met = 1'b1;
    endcase
  end

  assign is_branch = (op == op_b) || (op == op_br);
  assign is_br_reg = (op == op_br);
  assign br_taken = is_branch && cond_met;
  assign br_target = is_br_reg ? rs_val
                   : if_id.pc_plus2 + {{6{if_id.inst[8]}}, if_id.inst[8:0], 1'b0};

  always_comb begin
    id_ex.op = op;
    id_ex.rs_val = rs_val;
    id_ex.rt_val = rt_val;
    id_ex.shamt = if_id.inst[3:0];
    id_ex.rs = rs;
    id_ex.rt = rt;
    id_ex.rd = rd;
    id_ex.pc_plus2 = if_id.pc_plus2;
    // Writes to r0 are dropped here
    id_ex.reg_write = (!op[3] || op == op_lw || op == op_llb || op == op_lhb || op == op_pcs)
                      && (rd != '0);
    id_ex.mem_read = (op == op_lw);
    id_ex.mem_write = (op == op_sw);
    id_ex.halt = (op == op_hlt);
    // LW/SW offset in halfwords, LLB/LHB byte in place
    case (op)
      op_llb:  id_ex.imm = {8'h00, if_id.inst[7:0]};
      op_lhb:  id_ex.imm = {if_id.inst[7:0], 8'h00};
      default: id_ex.imm = {{11{if_id.inst[3]}}, if_id.inst[3:0], 1'b0};
    endcase
  end

endmodule

`default_nettype wire

// File: hazard_unit.sv
`default_nettype none

module hazard_unit (
  ex_mem_if.hzd                          ex_mem,
  input  cpu_pkg::id_ex_t                id_ex,
  input  logic [cpu_pkg::reg_addr_w-1:0] mem_wb_rd,
  input  logic                           mem_wb_en,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs,
  input  logic [cpu_pkg::reg_addr_w-1:0] rt,
  input  logic                           uses_rt,
  input  logic                           is_branch,
  input  logic                           is_br_reg,
  input  logic                           br_taken,
  output logic                           stall,
  output logic                           flush,
  output cpu_pkg::fwd_sel_t              fwd_a,
  output cpu_pkg::fwd_sel_t              fwd_b,
  output cpu_pkg::fwd_sel_t              fwd_store
);
  import cpu_pkg::*;

  logic     load_use;
  logic     flag_wait;
  logic     reg_wait;
  fwd_sel_t sel_rs;
  fwd_sel_t sel_rt;

  function automatic fwd_sel_t pick(input logic [reg_addr_w-1:0] src);
    // EX/MEM first, load data there is not ready yet
    if (src != '0 && ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == src) begin
      return fwd_ex_mem;
    end else if (src != '0 && mem_wb_en && mem_wb_rd == src) begin
      return fwd_mem_wb;
    end
    return fwd_none;
  endfunction

  assign load_use = id_ex.mem_read && id_ex.rd != '0
                    && (id_ex.rd == rs || (uses_rt && id_ex.rd == rt));
  // Ops below 1000 all write flags
  assign flag_wait = is_branch && !id_ex.op[3];
  assign reg_wait = is_br_reg && rs != '0
                    && ((id_ex.reg_write && id_ex.rd == rs)
                        || (ex_mem.reg_write && ex_mem.rd == rs));

  assign stall = load_use || flag_wait || reg_wait;
  assign flush = br_taken && !stall;

  assign sel_rs = pick(id_ex.rs);
  assign sel_rt = pick(id_ex.rt);
  assign fwd_a = sel_rs;
  assign fwd_b = id_ex.mem_write ? fwd_none : sel_rt;
  assign fwd_store = id_ex.mem_write ? sel_rt : fwd_none;

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
  input  cpu_pkg::opcode_t           op,
  input  logic [cpu_pkg::data_w-1:0] a,
  input  logic [cpu_pkg::data_w-1:0] b,
  input  logic [3:0]                 shamt,
  output logic [cpu_pkg::data_w-1:0] result,
  output cpu_pkg::flags_t            flags_out,
  output cpu_pkg::flags_t            flags_wen
);
  import cpu_pkg::*;

  logic [data_w-1:0]   sum;
  logic [data_w-1:0]   diff;
  logic                add_ovf;
  logic                sub_ovf;
  logic [2*data_w-1:0] rot;

  assign sum = a + b;
  assign diff = a - b;
  // Signed overflow from operand and result signs
  assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
  assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);
  assign rot = {a, a} >> shamt;

  always_comb begin
    case (op)
      // Clamp toward the sign of a
      op_add:  result = add_ovf ? (a[15] ? 16'h8000 : 16'h7FFF) : sum;
      op_sub:  result = sub_ovf ? (a[15] ? 16'h8000 : 16'h7FFF) : diff;
      op_xor:  result = a ^ b;
      op_sll:  result = a << shamt;
      op_sra:  result = $signed(a) >>> shamt;
      op_ror:  result = rot[data_w-1:0];
      // Address with bit 0 of the base cleared, no saturation
      op_lw, op_sw: result = {a[15:1], 1'b0} + b;
      default: result = sum;
    endcase
  end

  assign flags_out.z = (result == '0);
  assign flags_out.v = (op == op_sub) ? sub_ovf : add_ovf;
  assign flags_out.n = result[15];

  // ADD/SUB write all three, logic and shifts only Z
  always_comb begin
    case (op)
      op_add, op_sub:                 flags_wen = 3'b111;
      op_xor, op_sll, op_sra, op_ror: flags_wen = 3'b100;
      default:                        flags_wen = 3'b000;
    endcase
  end

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cpu_pkg::id_ex_t            id_ex,
  input  cpu_pkg::fwd_sel_t          fwd_a,
  input  cpu_pkg::fwd_sel_t          fwd_b,
  input  cpu_pkg::fwd_sel_t          fwd_store,
  input  logic [cpu_pkg::data_w-1:0] wb_data,
  ex_mem_if.ex                       ex_mem,
  output cpu_pkg::flags_t            flags
);
  import cpu_pkg::*;

  logic [data_w-1:0] op_a;
  logic [data_w-1:0] op_b;
  logic [data_w-1:0] store_val;
  logic [data_w-1:0] alu_b;
  logic [data_w-1:0] alu_res;
  logic [data_w-1:0] merged;
  logic [data_w-1:0] ex_res;
  flags_t            alu_flags;
  flags_t            alu_wen;

  function automatic logic [data_w-1:0] fwd_mux(input fwd_sel_t sel,
                                                input logic [data_w-1:0] reg_val);
    case (sel)
      fwd_ex_mem: return ex_mem.alu_out;
      fwd_mem_wb: return wb_data;
      default:    return reg_val;
    endcase
  endfunction

  assign op_a = fwd_mux(fwd_a, id_ex.rs_val);
  assign op_b = fwd_mux(fwd_b, id_ex.rt_val);
  assign store_val = fwd_mux(fwd_store, id_ex.rt_val);
  // Memory ops take the offset as second operand
  assign alu_b = id_ex.mem_read || id_ex.mem_write ? id_ex.imm : op_b;

  alu u_alu (
    .op        (id_ex.op),
    .a         (op_a),
    .b         (alu_b),
    .shamt     (id_ex.shamt),
    .result    (alu_res),
    .flags_out (alu_flags),
    .flags_wen (alu_wen)
  );

  // Keep the other byte of the old destination value
  assign merged = (id_ex.op == op_lhb) ? ((op_b & 16'h00FF) | id_ex.imm)
                                       : ((op_b & 16'hFF00) | id_ex.imm);

  always_comb begin
    case (id_ex.op)
      op_pcs:         ex_res = id_ex.pc_plus2;
      op_llb, op_lhb: ex_res = merged;
      default:        ex_res = alu_res;
    endcase
  end

  // Flags update as the instruction leaves EX, bit by bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else begin
      flags <= (alu_flags & alu_wen) | (flags & ~alu_wen);
    end
  end

  // EX/MEM control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.halt <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex.reg_write || id_ex.mem_read || id_ex.mem_write || id_ex.halt;
      ex_mem.reg_write <= id_ex.reg_write;
      ex_mem.mem_read <= id_ex.mem_read;
      ex_mem.mem_write <= id_ex.mem_write;
      ex_mem.halt <= id_ex.halt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    ex_mem.rd <= id_ex.rd;
    ex_mem.alu_out <= ex_res;
    ex_mem.store_data <= store_val;
  end

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
`default_nettype none

module mem_wb_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  ex_mem_if.mem                          ex_mem,
  output logic [cpu_pkg::data_w-1:0]     dmem_addr,
  output logic [cpu_pkg::data_w-1:0]     dmem_wdata,
  output logic                           dmem_rd,
  output logic                           dmem_wr,
  input  logic [cpu_pkg::data_w-1:0]     dmem_rdata,
  output logic                           wb_en,
  output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
  output logic [cpu_pkg::data_w-1:0]     wb_data,
  output logic                           hlt
);
  import cpu_pkg::*;

  mem_wb_t mem_wb;

  // Single-cycle data port straight from EX/MEM
  assign dmem_addr = ex_mem.alu_out;
  assign dmem_wdata = ex_mem.store_data;
  assign dmem_rd = ex_mem.valid && ex_mem.mem_read;
  assign dmem_wr = ex_mem.valid && ex_mem.mem_write;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_read;
      mem_wb.rd <= ex_mem.rd;
      mem_wb.alu <= ex_mem.alu_out;
      mem_wb.load_data <= dmem_rdata;
      // Sticky, rises as HLT enters MEM/WB
      mem_wb.halt <= mem_wb.halt || ex_mem.halt;
    end
  end

  assign wb_en = mem_wb.reg_write;
  assign wb_rd = mem_wb.rd;
  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu;
  assign hlt = mem_wb.halt;

endmodule

`default_nettype wire

// File: cpu_top.sv
`default_nettype none

module cpu_top (
  input  logic                       clk,
  input  logic                       rst_n,
  output logic [cpu_pkg::data_w-1:0] inst_addr,
  input  logic [cpu_pkg::data_w-1:0] inst,
  output logic [cpu_pkg::data_w-1:0] dmem_addr,
  output logic [cpu_pkg::data_w-1:0] dmem_wdata,
  output logic                       dmem_rd,
  output logic                       dmem_wr,
  input  logic [cpu_pkg::data_w-1:0] dmem_rdata,
  output logic [cpu_pkg::data_w-1:0] pc,
  output logic                       hlt
);
  import cpu_pkg::*;

  if_id_t                if_id_d;
  if_id_t                if_id_q;
  id_ex_t                id_ex_d;
  id_ex_t                id_ex_q;
  if_id_t                if_id_nop;
  id_ex_t                id_ex_nop;
  logic                  stall;
  logic                  flush;
  logic                  br_taken;
  logic [data_w-1:0]     br_target;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic                  uses_rt;
  logic                  is_branch;
  logic                  is_br_reg;
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_rd;
  logic [data_w-1:0]     wb_data;
  flags_t                flags;
  fwd_sel_t              fwd_a;
  fwd_sel_t              fwd_b;
  fwd_sel_t              fwd_store;

  ex_mem_if u_ex_mem ();

  // Bubbles are the no-effect LLB r0
  assign if_id_nop = '{inst: nop_inst, pc_plus2: '0};
  always_comb begin
    id_ex_nop = '0;
    id_ex_nop.op = op_llb;
  end

  assign inst_addr = pc;

  fetch_stage u_fetch (
    .clk(clk), .rst_n(rst_n), .inst(inst), .stall(stall), .br_taken(br_taken),
    .br_target(br_target), .pc(pc), .if_id(if_id_d)
  );

  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .rst_n(rst_n), .hold(stall), .clear(flush), .bubble(if_id_nop),
    .d(if_id_d), .q(if_id_q)
  );

  decode_stage u_decode (
    .clk(clk), .rst_n(rst_n), .if_id(if_id_q), .wb_en(wb_en), .wb_rd(wb_rd),
    .wb_data(wb_data), .flags(flags), .id_ex(id_ex_d), .rs(rs), .rt(rt),
    .uses_rt(uses_rt), .is_branch(is_branch), .is_br_reg(is_br_reg),
    .br_taken(br_taken), .br_target(br_target)
  );

  // Stall drops a bubble into ID/EX
  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .rst_n(rst_n), .hold(1'b0), .clear(stall), .bubble(id_ex_nop),
    .d(id_ex_d), .q(id_ex_q)
  );

  hazard_unit u_hazard (
    .ex_mem(u_ex_mem.hzd), .id_ex(id_ex_q), .mem_wb_rd(wb_rd), .mem_wb_en(wb_en),
    .rs(rs), .rt(rt), .uses_rt(uses_rt), .is_branch(is_branch), .is_br_reg(is_br_reg),
    .br_taken(br_taken), .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .fwd_store(fwd_store)
  );

  execute_stage u_execute (
    .clk(clk), .rst_n(rst_n), .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .fwd_store(fwd_store), .wb_data(wb_data), .ex_mem(u_ex_mem.ex), .flags(flags)
  );

  mem_wb_stage u_mem_wb (
    .clk(clk), .rst_n(rst_n), .ex_mem(u_ex_mem.mem), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_rd(dmem_rd), .dmem_wr(dmem_wr),
    .dmem_rdata(dmem_rdata), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .hlt(hlt)
  );

endmodule

`default_nettype wire

// File: cpu_chk.sv
`default_nettype none

module cpu_chk (
  input logic                       clk,
  input logic                       rst_n,
  input logic [cpu_pkg::data_w-1:0] pc,
  input logic                       hlt,
  input logic                       dmem_rd,
  input logic                       dmem_wr
);

  // One data access per cycle at most
  a_single_access: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_rd && dmem_wr))
    else $error("dmem_rd and dmem_wr high in the same cycle");

  // Halted core keeps its fetch address
  a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    hlt |=> $stable(pc))
    else $error("pc moved while hlt was high");

  // Sticky until reset
  a_hlt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    hlt |=> hlt)
    else $error("hlt fell without a reset");

endmodule

bind cpu_top cpu_chk u_cpu_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .pc      (pc),
  .hlt     (hlt),
  .dmem_rd (dmem_rd),
  .dmem_wr (dmem_wr)
);

`default_nettype wire

// File: tb_cpu_top.sv
`default_nettype none

module tb_cpu_top;
  import cpu_pkg::*;

  localparam int mem_words = 256;
  localparam int n_random = 120;

  logic              clk;
  logic              rst_n;
  logic [data_w-1:0] inst_addr;
  logic [data_w-1:0] inst;
  logic [data_w-1:0] dmem_addr;
  logic [data_w-1:0] dmem_wdata;
  logic              dmem_rd;
  logic              dmem_wr;
  logic [data_w-1:0] dmem_rdata;
  logic [data_w-1:0] pc;
  logic              hlt;

  logic [15:0] imem [mem_words];
  logic [15:0] dmem [mem_words];
  // Model store sequence, address in the upper half
  logic [31:0] exp_stores [$];
  logic [31:0] seed;
  logic [15:0] halt_pc;
  int          prog_len;
  int          model_total;
  int          model_loads;
  int          limit;
  int          cycles;
  int          checks;
  int          errors;
  int          store_count;
  int          load_count;

  cpu_top u_cpu_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_addr  (inst_addr),
    .inst       (inst),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_rd    (dmem_rd),
    .dmem_wr    (dmem_wr),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .hlt        (hlt)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Every address bit shows up in the word
  function automatic logic [15:0] mem_pattern(input logic [7:0] idx);
    return {idx, ~idx} ^ 16'h5A96;
  endfunction

  function automatic logic [3:0] op_for(input int kind);
    case (kind)
      0: return 4'h0;
      1: return 4'h1;
      2: return 4'h2;
      3: return 4'h4;
      4: return 4'h5;
      5: return 4'h6;
      6: return 4'h8;
      7: return 4'h9;
      8: return 4'hA;
      9: return 4'hB;
      10: return 4'hC;
      default: return 4'hE;
    endcase
  endfunction

  // Branch condition table
  function automatic logic cond_holds(input logic [2:0] c, input logic z, v, n);
    case (c)
      3'd0: return !z;
      3'd1: return z;
      3'd2: return !z && !n;
      3'd3: return n;
      3'd4: return z || (!z && !n);
      3'd5: return n || z;
      3'd6: return v;
      default: return 1'b1;
    endcase
  endfunction

  task automatic build_program();
    int          idx;
    int          last;
    int          off;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [15:0] target;
    // Unused words halt a runaway fetch
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = 16'hF000;
    end
    idx = 0;
    for (int i = 1; i < 15; i++) begin
      seed = xorshift32(seed);
      imem[idx] = {4'hA, 4'(i), seed[7:0]};
      imem[idx + 1] = {4'hB, 4'(i), seed[15:8]};
      idx += 2;
    end
    // r15 is the load/store base, 0x0100
    imem[idx] = 16'hAF00;
    imem[idx + 1] = 16'hBF01;
    idx += 2;
    last = idx + n_random;
    while (idx < last) begin
      seed = xorshift32(seed);
      op = op_for(int'(seed[7:0]) % 12);
      rd = 4'(1 + int'(seed[31:28]) % 14);
      case (op)
        4'h8: imem[idx] = {op, rd, 4'hF, seed[15:12]};
        4'h9: imem[idx] = {op, seed[11:8], 4'hF, seed[15:12]};
        4'hA, 4'hB, 4'hE: imem[idx] = {op, rd, seed[23:16]};
        4'hC: begin
          // Forward only, never past the random block
          off = int'(seed[18:16]);
          if (off > last - idx - 1) begin
            off = last - idx - 1;
          end
          imem[idx] = {op, seed[11:9], 9'(off)};
        end
        default: imem[idx] = {op, rd, seed[11:8], seed[15:12]};
      endcase
      idx++;
    end
    // Directed BR over two stores
    target = 16'((idx + 5) * 2);
    imem[idx] = {4'hA, 4'hD, target[7:0]};
    imem[idx + 1] = {4'hB, 4'hD, target[15:8]};
    imem[idx + 2] = {4'hD, 3'b111, 1'b0, 4'hD, 4'h0};
    imem[idx + 3] = {4'h9, 4'h1, 4'hF, 4'h7};
    imem[idx + 4] = {4'h9, 4'h2, 4'hF, 4'h7};
    idx += 5;
    // Epilogue, r1..r15 to base -8..+6 words
    for (int i = 1; i < 16; i++) begin
      imem[idx] = {4'h9, 4'(i), 4'hF, 4'(i - 9)};
      idx++;
    end
    imem[idx] = 16'hF000;
    prog_len = idx + 1;
  endtask

  // ISA-level execution of the program
  task automatic run_model();
    logic [15:0] r [16];
    logic [15:0] mem [mem_words];
    logic [15:0] mpc;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    logic        z;
    logic        v;
    logic        n;
    logic        wr;
    int          sum;
    int          steps;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = mem_pattern(8'(i));
    end
    mpc = '0;
    z = 1'b0;
    v = 1'b0;
    n = 1'b0;
    steps = 0;
    w = imem[mpc[8:1]];
    while (w[15:12] != 4'hF && steps < 4 * mem_words) begin
      a = r[w[7:4]];
      b = r[w[3:0]];
      res = '0;
      wr = 1'b1;
      addr = (a & 16'hFFFE) + 16'($signed(w[3:0]) * 2);
      case (w[15:12])
        4'h0, 4'h1: begin
          sum = w[12] ? $signed(a) - $signed(b) : $signed(a) + $signed(b);
          v = (sum > 32767) || (sum < -32768);
          res = (sum > 32767) ? 16'h7FFF : (sum < -32768) ? 16'h8000 : 16'(sum);
          z = (res == '0);
          n = res[15];
        end
        4'h2: begin
          res = a ^ b;
          z = (res == '0);
        end
        4'h4, 4'h5, 4'h6: begin
          res = a;
          // One bit position per step
          repeat (w[3:0]) begin
            case (w[13:12])
              2'b00: res = {res[14:0], 1'b0};
              2'b01: res = {res[15], res[15:1]};
              default: res = {res[0], res[15:1]};
            endcase
          end
          z = (res == '0);
        end
        4'h8: begin
          res = mem[addr[8:1]];
          model_loads++;
        end
        4'h9: begin
          wr = 1'b0;
          mem[addr[8:1]] = r[w[11:8]];
          exp_stores.push_back({addr, r[w[11:8]]});
        end
        4'hA: res = {r[w[11:8]][15:8], w[7:0]};
        4'hB: res = {w[7:0], r[w[11:8]][7:0]};
        4'hE: res = mpc + 16'd2;
        default: wr = 1'b0;
      endcase
      if (wr && w[11:8] != 4'h0) begin
        r[w[11:8]] = res;
      end
      if (w[15:12] == 4'hC && cond_holds(w[11:9], z, v, n)) begin
        mpc = mpc + 16'd2 + 16'($signed(w[8:0]) * 2);
      end else if (w[15:12] == 4'hD && cond_holds(w[11:9], z, v, n)) begin
        mpc = a;
      end else begin
        mpc = mpc + 16'd2;
      end
      w = imem[mpc[8:1]];
      steps++;
    end
    halt_pc = mpc;
    assert (w[15:12] == 4'hF) else begin
      errors++;
      $display("Model ran %0d steps without reaching HLT", steps);
    end
  endtask

  // Check the current cycle, then drive both memory read ports
  task automatic service_cycle();
    logic [31:0] exp;
    if (dmem_rd || dmem_wr) begin
      checks++;
      assert (dmem_addr[15:9] == '0) else begin
        errors++;
        $display("Data access at %h falls outside the 256-word memory", dmem_addr);
      end
    end
    if (dmem_rd) begin
      load_count++;
    end
    if (dmem_wr) begin
      store_count++;
      checks++;
      assert (exp_stores.size() != 0) else begin
        errors++;
        $display("Store %0d to %h has no counterpart in the model", store_count, dmem_addr);
      end
      if (exp_stores.size() != 0) begin
        exp = exp_stores.pop_front();
        assert ({dmem_addr, dmem_wdata} == exp) else begin
          errors++;
          $display("[ERROR] store_%0d: expected %h:%h, actual %h:%h", store_count,
                   exp[31:16], exp[15:0], dmem_addr, dmem_wdata);
        end
      end
      dmem[dmem_addr[8:1]] = dmem_wdata;
    end
    inst = imem[inst_addr[8:1]];
    dmem_rdata = dmem[dmem_addr[8:1]];
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b1;
    inst = nop_inst;
    dmem_rdata = '0;
    cycles = 0;
    checks = 0;
    errors = 0;
    store_count = 0;
    load_count = 0;
    model_loads = 0;
    seed = 32'h97124946;
    for (int i = 0; i < mem_words; i++) begin
      dmem[i] = mem_pattern(8'(i));
    end
    build_program();
    run_model();
    model_total = exp_stores.size();
    // Eight cycles per program word
    limit = 8 * prog_len;
    #1;
    rst_n = 1'b0;
    #1;
    // Reset state before the first clock edge
    checks++;
    assert (pc == '0 && !hlt && !dmem_rd && !dmem_wr) else begin
      errors++;
      $display("[ERROR] reset_state: expected pc=0000 hlt=0 rd=0 wr=0, %s",
               $sformatf("actual pc=%h hlt=%b rd=%b wr=%b", pc, hlt, dmem_rd, dmem_wr));
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    inst = imem[inst_addr[8:1]];
    while (!hlt && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
      service_cycle();
    end
    if (!hlt) begin
      errors++;
      $display("Timeout after %0d cycles, hlt never rose", cycles);
    end else begin
      checks += 3;
      assert (pc == halt_pc) else begin
        errors++;
        $display("[ERROR] halt_pc: expected %h, actual %h", halt_pc, pc);
      end
      assert (store_count == model_total) else begin
        errors++;
        $display("[ERROR] store_count: expected %0d, actual %0d", model_total, store_count);
      end
      assert (load_count == model_loads) else begin
        errors++;
        $display("[ERROR] load_count: expected %0d, actual %0d", model_loads, load_count);
      end
    end
    $display("Summary: cycles=%0d checks=%0d stores=%0d/%0d loads=%0d/%0d errors=%0d",
             cycles, checks, store_count, model_total, load_count, model_loads, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
cpu_pkg.sv
ex_mem_if.sv
pipe_reg.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
alu.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
cpu_chk.sv
tb_cpu_top.sv

// File: Bender.yml
package:
  name: cpu16_pipeline

sources:
  - files:
      - cpu_pkg.sv
      - ex_mem_if.sv
      - pipe_reg.sv
      - fetch_stage.sv
      - decode_stage.sv
      - hazard_unit.sv
      - alu.sv
      - execute_stage.sv
      - mem_wb_stage.sv
      - cpu_top.sv
  - target: test
    files:
      - cpu_chk.sv
      - tb_cpu_top.sv
